// File: alu.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module alu import cpu_pkg::*; (
  input  alu_op_t          op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] result,
  output flags_t           flags
);

  localparam int MSB = `XLEN - 1;

  logic [`XLEN:0] sum;
  logic [`XLEN:0] diff;  // top bit is the borrow
  logic [4:0]     shamt;

  assign sum   = {1'b0, a} + {1'b0, b};
  assign diff  = {1'b0, a} - {1'b0, b};
  assign shamt = b[4:0];

  always_comb begin
    result         = '0;
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    case (op)
      alu_add: begin
        result         = sum[MSB:0];
        flags.carry    = sum[`XLEN];
        flags.overflow = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
      end
      alu_sub, alu_cmp: begin  // cmp only keeps the flags
        result         = diff[MSB:0];
        flags.carry    = diff[`XLEN];
        flags.overflow = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
      end
      alu_not:  result = ~a;
      alu_and:  result = a & b;
      alu_test: result = a & b;
      alu_or:   result = a | b;
      alu_nand: result = ~(a & b);
      alu_nor:  result = ~(a | b);
      alu_mov:  result = b;
      alu_sar:  result = $signed(a) >>> shamt;
      alu_shr:  result = a >> shamt;
      alu_shl:  result = a << shamt;
      alu_xor:  result = a ^ b;
      default:  result = '0;
    endcase
    flags.zero = (result == '0);
    flags.sign = result[MSB];
  end

endmodule

// File: branch_unit.sv
`timescale 1ns/100ps

module branch_unit import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  flags_t  flags_in,
  input  logic    flags_write,
  input  jmp_op_t jop,
  output logic    take
);

  flags_t flags_q;
  logic   less;

  always_ff @(posedge clk) begin
    if (reset)
      flags_q <= '0;
    else if (flags_write)
      flags_q <= flags_in;
  end

  assign less = flags_q.sign ^ flags_q.overflow;  // signed a < b

  always_comb begin
    case (jop)
      jmp_j:           take = 1'b1;
      jmp_je, jmp_jz:  take = flags_q.zero;
      jmp_jne, jmp_jnz: take = !flags_q.zero;
      jmp_jl:          take = less;
      jmp_jle:         take = less || flags_q.zero;
      jmp_jg:          take = !(less || flags_q.zero);
      jmp_jge:         take = !less;
      jmp_jo:          take = flags_q.overflow;
      default:         take = 1'b0;
    endcase
  end

endmodule

// File: compile.f
+incdir+.
cpu_pkg.sv
mem_req_if.sv
control_unit.sv
alu.sv
register_file.sv
branch_unit.sv
load_store_unit.sv
cpu_core.sv
tb_checker.sv
tb_top.sv

// File: control_unit.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module control_unit import cpu_pkg::*; (
  input  logic [`OP_CODE_BITS-1:0] opcode,
  output ctrl_t                    ctrl
);

  always_comb begin
    ctrl = '{
      reg_dst:     1'b0,
      alu_src:     1'b0,
      mem_to_reg:  1'b0,
      reg_write:   1'b0,
      address_src: 1'b0,
      flags_write: 1'b0,
      halt:        1'b0,
      alu_op:      alu_nop,
      mem_op:      mem_nop,
      jop:         jmp_nop
    };

    // operand routing by group
    case (opcode[`OP_CODE_BITS-1 -: 2])
      2'b00:   ctrl.reg_dst = 1'b1;     // ra op rb -> rc
      2'b01:   ctrl.alu_src = 1'b1;     // ra op imm -> rb
      2'b10:   ctrl.mem_to_reg = 1'b1;
      default: ;
    endcase

    case (opcode)
      `OP_CODE_ADD,  `OP_CODE_ADDI:  ctrl.alu_op = alu_add;
      `OP_CODE_SUB,  `OP_CODE_SUBI:  ctrl.alu_op = alu_sub;
      `OP_CODE_NOT,  `OP_CODE_NOTI:  ctrl.alu_op = alu_not;
      `OP_CODE_AND,  `OP_CODE_ANDI:  ctrl.alu_op = alu_and;
      `OP_CODE_OR,   `OP_CODE_ORI:   ctrl.alu_op = alu_or;
      `OP_CODE_NAND, `OP_CODE_NANDI: ctrl.alu_op = alu_nand;
      `OP_CODE_NOR,  `OP_CODE_NORI:  ctrl.alu_op = alu_nor;
      `OP_CODE_MOV,  `OP_CODE_MOVI:  ctrl.alu_op = alu_mov;
      `OP_CODE_SAR,  `OP_CODE_SARI:  ctrl.alu_op = alu_sar;
      `OP_CODE_SHR,  `OP_CODE_SHRI:  ctrl.alu_op = alu_shr;
      `OP_CODE_SHL,  `OP_CODE_SHLI:  ctrl.alu_op = alu_shl;
      `OP_CODE_XOR,  `OP_CODE_XORI:  ctrl.alu_op = alu_xor;
      `OP_CODE_TEST, `OP_CODE_TESTI: ctrl.alu_op = alu_test;
      `OP_CODE_CMP,  `OP_CODE_CMPI:  ctrl.alu_op = alu_cmp;

      `OP_CODE_LW: ctrl.mem_op = mem_read;
      `OP_CODE_SW: ctrl.mem_op = mem_write;
      `OP_CODE_LA: begin
        ctrl.address_src = 1'b1;
        ctrl.mem_op      = mem_read;
      end
      `OP_CODE_SA: begin
        ctrl.address_src = 1'b1;
        ctrl.mem_op      = mem_write;
      end

      `OP_CODE_JMP: ctrl.jop = jmp_j;
      `OP_CODE_JE:  ctrl.jop = jmp_je;
      `OP_CODE_JNE: ctrl.jop = jmp_jne;
      `OP_CODE_JL:  ctrl.jop = jmp_jl;
      `OP_CODE_JLE: ctrl.jop = jmp_jle;
      `OP_CODE_JG:  ctrl.jop = jmp_jg;
      `OP_CODE_JGE: ctrl.jop = jmp_jge;
      `OP_CODE_JZ:  ctrl.jop = jmp_jz;
      `OP_CODE_JNZ: ctrl.jop = jmp_jnz;
      `OP_CODE_JO:  ctrl.jop = jmp_jo;
      `OP_CODE_HLT: ctrl.halt = 1'b1;
      default: ;  // unknown opcode, falls out as a nop
    endcase

    // write enables follow from the decoded operation
    if (ctrl.alu_op != alu_nop) begin
      ctrl.flags_write = 1'b1;
      ctrl.reg_write   = !(ctrl.alu_op inside {alu_test, alu_cmp});
    end
    if (ctrl.mem_op == mem_read)
      ctrl.reg_write = 1'b1;

    // memory ops must never carry a jump
    assert (ctrl.mem_op == mem_nop || ctrl.jop == jmp_nop)
      else $error("control_unit: opcode %b decodes to memory op and jump", opcode);
  end

endmodule

// File: cpu_core.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic             dmem_valid,
  input  logic             dmem_ready,
  output logic             dmem_write,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wdata,
  input  logic             dmem_rvalid,
  input  logic [`XLEN-1:0] dmem_rdata,
  output logic             halted
);

  typedef enum logic [1:0] {
    s_fetch,
    s_decode,    // instruction word arrives from imem
    s_execute,
    s_mem_wait
  } core_state_t;

  core_state_t               state;
  logic [`XLEN-1:0]          pc;
  logic [`XLEN-1:0]          ir;
  logic [`REG_ADDR_BITS-1:0] ra;
  logic [`REG_ADDR_BITS-1:0] rb;
  logic [`REG_ADDR_BITS-1:0] rc;
  logic [`XLEN-1:0]          imm_ext;
  ctrl_t                     ctrl;
  logic [`XLEN-1:0]          ra_data;
  logic [`XLEN-1:0]          rb_data;
  logic [`XLEN-1:0]          alu_b;
  logic [`XLEN-1:0]          alu_result;
  flags_t                    alu_flags;
  logic                      take;
  logic                      rf_we;

  mem_req_if mem_if ();

  assign ra      = ir[25:21];
  assign rb      = ir[20:16];
  assign rc      = ir[15:11];
  assign imm_ext = {{(`XLEN-`IMM_BITS){ir[`IMM_BITS-1]}}, ir[`IMM_BITS-1:0]};
  assign alu_b   = ctrl.alu_src ? imm_ext : rb_data;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= s_fetch;
      pc     <= '0;
      halted <= 1'b0;
    end else begin
      case (state)
        s_fetch:
          if (!halted)
            state <= s_decode;
        s_decode: state <= s_execute;
        s_execute:
          if (ctrl.halt) begin
            halted <= 1'b1;  // pc stays on the hlt word
            state  <= s_fetch;
          end else if (ctrl.mem_op != mem_nop) begin
            pc    <= pc + 1'b1;
            state <= s_mem_wait;
          end else begin
            pc    <= take ? imm_ext : pc + 1'b1;
            state <= s_fetch;
          end
        s_mem_wait:
          if (mem_if.done)
            state <= s_fetch;
        default: state <= s_fetch;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_decode)
      ir <= imem_data;
  end

  // request fields come from ir and registers, both frozen in mem_wait
  assign mem_if.valid = (state == s_mem_wait);
  assign mem_if.write = (ctrl.mem_op == mem_write);
  assign mem_if.addr  = ctrl.address_src ? imm_ext : ra_data + imm_ext;
  assign mem_if.wdata = rb_data;

  assign rf_we = ctrl.reg_write &&
                 ((state == s_execute && !ctrl.mem_to_reg) ||
                  (state == s_mem_wait && mem_if.done));

  control_unit u_control_unit (
    .opcode (ir[`XLEN-1 -: `OP_CODE_BITS]),
    .ctrl   (ctrl)
  );

  register_file u_register_file (
    .clk     (clk),
    .reset   (reset),
    .ra_addr (ra),
    .rb_addr (rb),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .we      (rf_we),
    .wr_addr (ctrl.reg_dst ? rc : rb),
    .wr_data (ctrl.mem_to_reg ? mem_if.rdata : alu_result)
  );

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (ra_data),
    .b      (alu_b),
    .result (alu_result),
    .flags  (alu_flags)
  );

  branch_unit u_branch_unit (
    .clk         (clk),
    .reset       (reset),
    .flags_in    (alu_flags),
    .flags_write (ctrl.flags_write && state == s_execute),
    .jop         (ctrl.jop),
    .take        (take)
  );

  load_store_unit u_load_store_unit (
    .clk         (clk),
    .reset       (reset),
    .req         (mem_if),
    .dmem_valid  (dmem_valid),
    .dmem_ready  (dmem_ready),
    .dmem_write  (dmem_write),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_rvalid (dmem_rvalid),
    .dmem_rdata  (dmem_rdata)
  );

  // the lsu must be idle whenever a new memory op is issued
  a_lsu_idle_on_issue: assert property (@(posedge clk) disable iff (reset)
    state == s_execute && ctrl.mem_op != mem_nop |=> mem_if.ready)
    else $error("cpu_core: memory op issued while lsu busy");

  a_done_in_mem_wait: assert property (@(posedge clk) disable iff (reset)
    mem_if.done |-> state == s_mem_wait)
    else $error("cpu_core: lsu done outside mem_wait");

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  typedef enum logic [3:0] {
    alu_nop,
    alu_add,
    alu_sub,
    alu_not,
    alu_and,
    alu_or,
    alu_nand,
    alu_nor,
    alu_mov,
    alu_sar,
    alu_shr,
    alu_shl,
    alu_xor,
    alu_test,
    alu_cmp
  } alu_op_t;

  typedef enum logic [1:0] {
    mem_nop,
    mem_read,
    mem_write
  } mem_op_t;

  typedef enum logic [3:0] {
    jmp_nop,
    jmp_j,     // unconditional
    jmp_je,
    jmp_jne,
    jmp_jl,
    jmp_jle,
    jmp_jg,
    jmp_jge,
    jmp_jz,
    jmp_jnz,
    jmp_jo
  } jmp_op_t;

  typedef struct packed {
    logic zero;
    logic sign;
    logic carry;
    logic overflow;
  } flags_t;

  typedef struct packed {
    logic    reg_dst;      // 1 selects rc, 0 selects rb
    logic    alu_src;      // 1 selects the immediate as operand b
    logic    mem_to_reg;
    logic    reg_write;
    logic    address_src;  // 1 for absolute addressing
    logic    flags_write;
    logic    halt;
    alu_op_t alu_op;
    mem_op_t mem_op;
    jmp_op_t jop;
  } ctrl_t;

endpackage

// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define XLEN          32
`define OP_CODE_BITS  6
`define REG_ADDR_BITS 5
`define IMM_BITS      16
`define NUM_REGS      32

// group 00, register forms
`define OP_CODE_ADD   6'b000000
`define OP_CODE_SUB   6'b000001
`define OP_CODE_NOT   6'b000010
`define OP_CODE_AND   6'b000011
`define OP_CODE_OR    6'b000100
`define OP_CODE_NAND  6'b000101
`define OP_CODE_NOR   6'b000110
`define OP_CODE_MOV   6'b000111
`define OP_CODE_SAR   6'b001000
`define OP_CODE_SHR   6'b001001
`define OP_CODE_SHL   6'b001010
`define OP_CODE_XOR   6'b001011
`define OP_CODE_TEST  6'b001100
`define OP_CODE_CMP   6'b001101

// group 01, immediate forms at the same low bits
`define OP_CODE_ADDI  6'b010000
`define OP_CODE_SUBI  6'b010001
`define OP_CODE_NOTI  6'b010010
`define OP_CODE_ANDI  6'b010011
`define OP_CODE_ORI   6'b010100
`define OP_CODE_NANDI 6'b010101
`define OP_CODE_NORI  6'b010110
`define OP_CODE_MOVI  6'b010111
`define OP_CODE_SARI  6'b011000
`define OP_CODE_SHRI  6'b011001
`define OP_CODE_SHLI  6'b011010
`define OP_CODE_XORI  6'b011011
`define OP_CODE_TESTI 6'b011100
`define OP_CODE_CMPI  6'b011101

// group 10, memory
`define OP_CODE_LW    6'b100000
`define OP_CODE_SW    6'b100001
`define OP_CODE_LA    6'b100010
`define OP_CODE_SA    6'b100011

// group 11, jumps and halt
`define OP_CODE_JMP   6'b110000
`define OP_CODE_JE    6'b110001
`define OP_CODE_JNE   6'b110010
`define OP_CODE_JL    6'b110011
`define OP_CODE_JLE   6'b110100
`define OP_CODE_JG    6'b110101
`define OP_CODE_JGE   6'b110110
`define OP_CODE_JZ    6'b110111
`define OP_CODE_JNZ   6'b111000
`define OP_CODE_JO    6'b111001
`define OP_CODE_HLT   6'b111111

`endif

// File: load_store_unit.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module load_store_unit (
  input  logic             clk,
  input  logic             reset,
  mem_req_if.lsu           req,
  output logic             dmem_valid,
  input  logic             dmem_ready,
  output logic             dmem_write,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wdata,
  input  logic             dmem_rvalid,
  input  logic [`XLEN-1:0] dmem_rdata
);

  typedef enum logic [1:0] {
    s_idle,
    s_request,
    s_wait_data
  } lsu_state_t;

  lsu_state_t       state;
  logic             done_q;
  logic             write_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] wdata_q;
  logic [`XLEN-1:0] rdata_q;

  // not ready in the done cycle, the core still holds valid then
  assign req.ready = (state == s_idle) && !done_q;
  assign req.done  = done_q;
  assign req.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= s_idle;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        s_idle:
          if (req.valid && req.ready)
            state <= s_request;
        s_request:
          if (dmem_ready) begin
            if (write_q) begin
              state  <= s_idle;
              done_q <= 1'b1;  // write completes on acceptance
            end else begin
              state <= s_wait_data;
            end
          end
        s_wait_data:
          if (dmem_rvalid) begin
            state  <= s_idle;
            done_q <= 1'b1;
          end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req.valid && req.ready) begin
      write_q <= req.write;
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
    if (state == s_wait_data && dmem_rvalid)
      rdata_q <= dmem_rdata;
  end

  assign dmem_valid = (state == s_request);
  assign dmem_write = write_q;
  assign dmem_addr  = addr_q;
  assign dmem_wdata = wdata_q;

  a_hold_under_stall: assert property (@(posedge clk) disable iff (reset)
    dmem_valid && !dmem_ready |=>
      dmem_valid && $stable({dmem_write, dmem_addr, dmem_wdata}))
    else $error("lsu: dmem request changed before dmem_ready");

  a_rvalid_expected: assert property (@(posedge clk) disable iff (reset)
    dmem_rvalid |-> state == s_wait_data)
    else $error("lsu: dmem_rvalid with no read outstanding");

endmodule

// File: mem_req_if.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

interface mem_req_if;
  logic             valid;
  logic             ready;  // lsu idle and able to take a request
  logic             write;
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] wdata;
  logic [`XLEN-1:0] rdata;
  logic             done;   // one cycle pulse at completion

  modport core (
    output valid, write, addr, wdata,
    input  ready, rdata, done
  );

  modport lsu (
    input  valid, write, addr, wdata,
    output ready, rdata, done
  );
endinterface

// File: register_file.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module register_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`REG_ADDR_BITS-1:0] ra_addr,
  input  logic [`REG_ADDR_BITS-1:0] rb_addr,
  output logic [`XLEN-1:0]          ra_data,
  output logic [`XLEN-1:0]          rb_data,
  input  logic                      we,
  input  logic [`REG_ADDR_BITS-1:0] wr_addr,
  input  logic [`XLEN-1:0]          wr_data
);

  // r0 has no storage, it reads as zero
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (!reset && we && wr_addr != '0)
      regs[wr_addr] <= wr_data;
  end

  assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
  assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f compile.f -o Vtb_top

out=$(./obj_dir/Vtb_top)
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
  exit 0
else
  exit 1
fi

// File: tb_checker.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module tb_checker (
  input logic             clk,
  input logic             reset,
  input logic [`XLEN-1:0] imem_addr,
  input logic             dmem_valid,
  input logic             dmem_ready,
  input logic             dmem_write,
  input logic [`XLEN-1:0] dmem_addr,
  input logic [`XLEN-1:0] dmem_wdata,
  input logic             halted
);

  logic [31:0] img [0:255];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_halt_pc;
  logic [31:0] held_addr;
  logic [31:0] held_wdata;
  logic        held_write;
  logic        hold_pending = 1'b0;
  logic        halted_q = 1'b0;
  bit          active = 1'b0;
  string       test_name;
  int          test_id;
  int          test_errors = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          store_count = 0;

  // data memory contents right after reset
  function automatic logic [31:0] initial_word(input int addr);
    return 32'h6b00_0000 + addr * 32'h0101_0027;
  endfunction

  // walks the program image by the ISA rules, collects stores and halt pc
  function automatic void reference_model();
    logic [31:0] regs [0:31];
    logic [31:0] mem [0:1023];
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [32:0] wide;
    logic [5:0]  op;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rc;
    logic        z;
    logic        s;
    logic        c;
    logic        v;
    logic        take;
    bit          done;
    int          steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 1024; i++) mem[i] = initial_word(i);
    {z, s, c, v} = '0;
    pc = '0;
    done = 0;
    steps = 0;
    while (!done && steps < 4000) begin
      ir  = img[pc[7:0]];
      op  = ir[31:26];
      ra  = ir[25:21];
      rb  = ir[20:16];
      rc  = ir[15:11];
      imm = {{16{ir[15]}}, ir[15:0]};
      steps++;
      case (op[5:4])
        2'b00, 2'b01: begin
          a = regs[ra];
          b = op[4] ? imm : regs[rb];
          if (op[3:0] <= 4'd13) begin
            c = 1'b0;
            v = 1'b0;
            case (op[3:0])
              4'd0: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[31:0];
                c = wide[32];
                v = (a[31] == b[31]) && (r[31] != a[31]);
              end
              4'd1, 4'd13: begin
                wide = {1'b0, a} - {1'b0, b};
                r = wide[31:0];
                c = wide[32];  // borrow
                v = (a[31] != b[31]) && (r[31] != a[31]);
              end
              4'd2:        r = ~a;
              4'd3, 4'd12: r = a & b;
              4'd4:        r = a | b;
              4'd5:        r = ~(a & b);
              4'd6:        r = ~(a | b);
              4'd7:        r = b;
              4'd8:        r = $signed(a) >>> b[4:0];
              4'd9:        r = a >> b[4:0];
              4'd10:       r = a << b[4:0];
              default:     r = a ^ b;
            endcase
            z = (r == '0);
            s = r[31];
            if (op[3:0] < 4'd12) begin  // test and cmp keep only flags
              if (op[4] && rb != '0) regs[rb] = r;
              if (!op[4] && rc != '0) regs[rc] = r;
            end
          end
          pc = pc + 1;
        end
        2'b10: begin
          if (op[3:2] == 2'b00) begin
            addr = op[1] ? imm : regs[ra] + imm;
            if (op[0]) begin
              exp_addr.push_back(addr);
              exp_data.push_back(regs[rb]);
              mem[addr[9:0]] = regs[rb];
            end else if (rb != '0) begin
              regs[rb] = mem[addr[9:0]];
            end
          end
          pc = pc + 1;
        end
        default: begin
          if (op == `OP_CODE_HLT) begin
            done = 1;
            exp_halt_pc = pc;
          end else begin
            case (op[3:0])
              4'd0:       take = 1'b1;
              4'd1, 4'd7: take = z;
              4'd2, 4'd8: take = !z;
              4'd3:       take = s ^ v;
              4'd4:       take = (s ^ v) || z;
              4'd5:       take = !((s ^ v) || z);
              4'd6:       take = !(s ^ v);
              4'd9:       take = v;
              default:    take = 1'b0;
            endcase
            pc = take ? imm : pc + 1;
          end
        end
      endcase
    end
    if (!done) begin
      $display("reference model found no halt in test %0d", test_id);
      test_errors++;
    end
  endfunction

  task automatic begin_test(input int id, input string name, input logic [31:0] image [0:255]);
    test_id = id;
    test_name = name;
    test_errors = 0;
    store_count = 0;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 256; i++) img[i] = image[i];
    reference_model();
    active = 1;
  endtask

  task automatic end_test();
    if (exp_addr.size() != 0) begin
      $display("%0d expected stores never appeared", exp_addr.size());
      test_errors++;
    end
    if (!halted) begin
      $display("core is not halted at the end of the test");
      test_errors++;
    end else if (imem_addr != exp_halt_pc) begin
      $display("core halted at pc %0d, expected pc %0d", imem_addr, exp_halt_pc);
      test_errors++;
    end
    if (test_errors == 0)
      $display("test %0d %s: ok, %0d stores", test_id, test_name, store_count);
    else
      $display("test %0d %s: %0d errors", test_id, test_name, test_errors);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    total_errors += test_errors;
    active = 0;
  endtask

  // inputs settle 1 ns after the rising edge, so the falling edge is quiet
  always @(negedge clk) begin
    if (reset || !active) begin
      hold_pending = 1'b0;
      halted_q = 1'b0;
    end else begin
      if (halted_q && !halted) begin
        $display("halted dropped without reset at %0t", $time);
        test_errors++;
      end
      if (dmem_valid && halted) begin
        $display("data request while halted at %0t", $time);
        test_errors++;
      end
      if (hold_pending) begin
        if (!dmem_valid) begin
          $display("dmem_valid dropped before dmem_ready at %0t", $time);
          test_errors++;
        end
        if (dmem_write != held_write) begin
          $display("FAIL %0t dmem_write expected %b actual %b", $time, held_write, dmem_write);
          test_errors++;
        end
        if (dmem_addr != held_addr) begin
          $display("FAIL %0t dmem_addr expected %h actual %h", $time, held_addr, dmem_addr);
          test_errors++;
        end
        if (dmem_wdata != held_wdata) begin
          $display("FAIL %0t dmem_wdata expected %h actual %h", $time, held_wdata, dmem_wdata);
          test_errors++;
        end
      end
      if (dmem_valid && dmem_ready && dmem_write) begin
        store_count++;
        if (exp_addr.size() == 0) begin
          $display("extra store to %h at %0t", dmem_addr, $time);
          test_errors++;
        end else begin
          if (dmem_addr != exp_addr[0]) begin
            $display("FAIL %0t dmem_addr expected %h actual %h", $time, exp_addr[0], dmem_addr);
            test_errors++;
          end
          if (dmem_wdata != exp_data[0]) begin
            $display("FAIL %0t dmem_wdata expected %h actual %h", $time, exp_data[0],
                     dmem_wdata);
            test_errors++;
          end
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
        end
      end
      hold_pending = dmem_valid && !dmem_ready;  // fields must hold next cycle
      held_addr = dmem_addr;
      held_wdata = dmem_wdata;
      held_write = dmem_write;
      halted_q = halted;
    end
  end

endmodule

// File: tb_top.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module tb_top;

  localparam int NUM_TESTS = 7;

  logic             clk;
  logic             reset;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_data = '0;
  logic             dmem_valid;
  logic             dmem_ready = 1'b0;
  logic             dmem_write;
  logic [`XLEN-1:0] dmem_addr;
  logic [`XLEN-1:0] dmem_wdata;
  logic             dmem_rvalid = 1'b0;
  logic [`XLEN-1:0] dmem_rdata = '0;
  logic             halted;

  logic [31:0] prog [0:255];
  logic [31:0] dmem [0:1023];
  int          prog_len;
  int          stall_min = 0;
  int          stall_max = 1;
  int          stall_cnt = 0;
  logic        rd_pend = 1'b0;
  int          rd_cnt = 0;
  logic [31:0] rd_addr = '0;
  logic        xfer = 1'b0;
  logic        xfer_write = 1'b0;
  logic [31:0] xfer_addr = '0;
  logic [31:0] xfer_wdata = '0;
  int          seed;
  longint      limit_ns;
  int          total_instr;

  cpu_core dut (.*);

  tb_checker chk (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .dmem_valid (dmem_valid),
    .dmem_ready (dmem_ready),
    .dmem_write (dmem_write),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // instruction word valid one cycle after its address
  always @(posedge clk) begin
    #1;
    imem_data = prog[imem_addr[7:0]];
  end

  always @(negedge clk) begin
    xfer       = dmem_valid && dmem_ready;
    xfer_write = dmem_write;
    xfer_addr  = dmem_addr;
    xfer_wdata = dmem_wdata;
  end

  // data memory with random stalls and read latency
  always @(posedge clk) begin
    #1;
    dmem_rvalid = 1'b0;
    if (reset) begin
      for (int i = 0; i < 1024; i++) dmem[i] = chk.initial_word(i);
      rd_pend = 1'b0;
      stall_cnt = 0;
      dmem_ready = 1'b0;
    end else begin
      if (rd_pend) begin
        if (rd_cnt == 0) begin
          dmem_rvalid = 1'b1;
          dmem_rdata = dmem[rd_addr[9:0]];
          rd_pend = 1'b0;
        end else begin
          rd_cnt--;
        end
      end
      if (xfer) begin
        if (xfer_write) begin
          dmem[xfer_addr[9:0]] = xfer_wdata;
        end else begin
          rd_pend = 1'b1;
          rd_cnt = $urandom_range(3, 0);  // 1 to 4 cycles
          rd_addr = xfer_addr;
        end
        stall_cnt = $urandom_range(stall_max, stall_min);
      end
      dmem_ready = (stall_cnt == 0);
      if (stall_cnt > 0 && dmem_valid) stall_cnt--;  // stall runs down against the next request
    end
  end

  function automatic logic [31:0] rtype(input logic [5:0] op, input logic [4:0] ra,
                                        input logic [4:0] rb, input logic [4:0] rc);
    return {op, ra, rb, rc, 11'b0};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] ra,
                                        input logic [4:0] rb, input logic [15:0] imm);
    return {op, ra, rb, imm};
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  task automatic alu_reg_program();
    emit(itype(`OP_CODE_MOVI, 0, 1, 16'h7ab3));
    emit(itype(`OP_CODE_SHLI, 1, 1, 16'd16));
    emit(itype(`OP_CODE_ORI, 1, 1, 16'h01c5));
    emit(itype(`OP_CODE_MOVI, 0, 2, 16'hfed4));  // -300
    emit(itype(`OP_CODE_MOVI, 0, 3, 16'd5));
    for (int k = 0; k < 12; k++) begin
      emit(rtype(6'(k), 1, (k >= 8 && k <= 10) ? 5'd3 : 5'd2, 4));
      emit(itype(`OP_CODE_SA, 0, 4, 16'(16 + k)));
    end
    emit(itype(`OP_CODE_MOVI, 0, 5, 16'hffff));
    emit(rtype(`OP_CODE_ADD, 5, 5, 6));  // carry out
    emit(itype(`OP_CODE_SA, 0, 6, 16'h001c));
  endtask

  task automatic alu_imm_program();
    logic [15:0] imms [0:11];
    imms = '{16'h0123, 16'hff80, 16'h7fff, 16'h8001, 16'h00f0, 16'hfff0,
             16'h1234, 16'habcd, 16'd3, 16'd17, 16'd9, 16'h5a5a};
    emit(itype(`OP_CODE_MOVI, 0, 1, 16'h8421));
    emit(itype(`OP_CODE_SHLI, 1, 1, 16'd12));
    for (int k = 0; k < 12; k++) begin
      emit(itype(6'(16 + k), 1, 5, imms[k]));
      emit(itype(`OP_CODE_SA, 0, 5, 16'(32 + k)));
    end
  endtask

  task automatic memory_program();
    emit(itype(`OP_CODE_LA, 0, 6, 16'h0040));
    emit(itype(`OP_CODE_SA, 0, 6, 16'h0080));
    emit(itype(`OP_CODE_MOVI, 0, 7, 16'h0020));
    emit(itype(`OP_CODE_LW, 7, 8, 16'h0025));
    emit(itype(`OP_CODE_SW, 7, 8, 16'h0070));
    emit(itype(`OP_CODE_MOVI, 0, 9, 16'h0060));
    emit(itype(`OP_CODE_SW, 9, 6, 16'hfff0));  // negative offset
    emit(itype(`OP_CODE_LA, 0, 10, 16'h0050));
    emit(itype(`OP_CODE_ADDI, 10, 10, 16'h0001));
    emit(itype(`OP_CODE_SA, 0, 10, 16'h0091));
    emit(itype(`OP_CODE_LW, 9, 11, 16'hffe5));
    emit(itype(`OP_CODE_SW, 7, 11, 16'h0300));
  endtask

  task automatic branch_program();
    int jop;
    emit(itype(`OP_CODE_MOVI, 0, 20, 16'h5aa5));
    for (int p = 0; p < 5; p++) begin
      case (p)
        0: begin
          emit(itype(`OP_CODE_MOVI, 0, 10, 16'd5));
          emit(itype(`OP_CODE_MOVI, 0, 11, 16'd5));
        end
        1: begin
          emit(itype(`OP_CODE_MOVI, 0, 10, 16'd3));
          emit(itype(`OP_CODE_MOVI, 0, 11, 16'd9));
        end
        2: begin
          emit(itype(`OP_CODE_MOVI, 0, 10, 16'd9));
          emit(itype(`OP_CODE_MOVI, 0, 11, 16'd3));
        end
        3: begin  // max positive minus -1 overflows
          emit(itype(`OP_CODE_MOVI, 0, 10, 16'hffff));
          emit(itype(`OP_CODE_SHRI, 10, 10, 16'd1));
          emit(itype(`OP_CODE_MOVI, 0, 11, 16'hffff));
        end
        default: begin
          emit(itype(`OP_CODE_MOVI, 0, 10, 16'hfff8));
          emit(itype(`OP_CODE_MOVI, 0, 11, 16'd4));
        end
      endcase
      for (int j = 1; j <= 11; j++) begin
        if (j <= 9) begin
          emit(rtype(`OP_CODE_CMP, 10, 11, 0));
          jop = j;
        end else begin
          emit(rtype(`OP_CODE_TEST, 10, 11, 0));
          jop = (j == 10) ? 7 : 8;  // jz, jnz
        end
        emit(itype({2'b11, 4'(jop)}, 0, 0, 16'(prog_len + 2)));
        emit(itype(`OP_CODE_SA, 0, 20, 16'(256 + p * 16 + j)));
      end
    end
    emit(itype(`OP_CODE_JMP, 0, 0, 16'(prog_len + 2)));
    emit(itype(`OP_CODE_SA, 0, 20, 16'h03f0));  // skipped
    emit(itype(`OP_CODE_SA, 0, 20, 16'h03f1));
  endtask

  task automatic build_program(input int sel);
    prog_len = 0;
    for (int i = 0; i < 256; i++) prog[i] = itype(`OP_CODE_HLT, 0, 0, 16'h0);
    case (sel)
      1:       alu_imm_program();
      2:       memory_program();
      3:       branch_program();
      default: alu_reg_program();
    endcase
    emit(itype(`OP_CODE_HLT, 0, 0, 16'h0));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic wait_halt();
    do begin
      @(posedge clk);
      #1;
    end while (!halted);
  endtask

  task automatic run_test(input int id, input string name, input int sel, input bit rebuild,
                          input int smin, input int smax, input int idle);
    if (rebuild) build_program(sel);
    stall_min = smin;
    stall_max = smax;
    chk.begin_test(id, name, prog);
    apply_reset();
    wait_halt();
    repeat (idle) @(posedge clk);
    #1;
    chk.end_test();
  endtask

  initial begin
    reset = 1'b1;
    seed = $urandom(23277);
    total_instr = 0;
    for (int s = 0; s < 4; s++) begin
      build_program(s);
      total_instr += (s == 0) ? 4 * prog_len : prog_len;
    end
    limit_ns = (longint'(total_instr) * 40 + NUM_TESTS * 100) * 8;
    fork
      begin
        #(limit_ns);
        $display("watchdog expired after %0d ns, core did not finish", limit_ns);
        $display("tests failed");
        $finish;
      end
    join_none

    run_test(0, "alu_reg", 0, 1, 0, 1, 10);
    run_test(1, "alu_imm", 1, 1, 0, 1, 10);
    run_test(2, "memory", 2, 1, 0, 1, 10);
    run_test(3, "branch", 3, 1, 0, 1, 10);
    run_test(4, "back_pressure", 0, 1, 2, 3, 10);
    run_test(5, "halt_hold", 0, 1, 0, 1, 40);
    run_test(6, "restart", 0, 0, 0, 1, 10);  // same image, reset only

    $display("tests run %0d, passed %0d, failed %0d", chk.tests_run,
             chk.tests_run - chk.tests_failed, chk.tests_failed);
    if (chk.total_errors == 0 && chk.tests_run == NUM_TESTS) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
